// File: hw/mem_cache_pkg.sv
/* widths, address fields, message and cache opcode enums,
   command header struct and bank geometry */
package mem_cache_pkg;

  localparam int NUM_BANKS_LP        = 2;
  localparam int SETS_LP             = 8;
  localparam int WORDS_PER_LINE_LP   = 4;
  localparam int ORDER_FIFO_DEPTH_LP = 4;
  localparam int ORDER_PTR_WIDTH_LP  = $clog2(ORDER_FIFO_DEPTH_LP);

  // byte address fields
  localparam int WORD_LSB_LP = 3;
  localparam int BANK_BIT_LP = 5;
  localparam int SET_LSB_LP  = 6;

  typedef logic [11:0] addr_t;
  typedef logic [63:0] data_t;
  typedef logic [7:0]  tag_t;
  typedef logic [0:0]  bank_id_t;
  typedef logic [2:0]  set_idx_t;
  typedef logic [1:0]  word_idx_t;

  typedef enum logic [1:0] {
    e_type_rd,
    e_type_wr,
    e_type_amo
  } msg_type_e;

  typedef enum logic [2:0] {
    e_subop_store,
    e_subop_amoswap,
    e_subop_amoadd,
    e_subop_amolr,
    e_subop_amosc
  } msg_subop_e;

  typedef enum logic [2:0] {
    e_size_1,
    e_size_2,
    e_size_4,
    e_size_8,
    e_size_16,
    e_size_32
  } msg_size_e;

  typedef enum logic [3:0] {
    e_op_lb,
    e_op_lh,
    e_op_lw,
    e_op_ld,
    e_op_sb,
    e_op_sh,
    e_op_sw,
    e_op_sd,
    e_op_amoswap_w,
    e_op_amoswap_d,
    e_op_amoadd_w,
    e_op_amoadd_d,
    e_op_tagst
  } cache_op_e;

  typedef enum logic [1:0] {
    e_state_reset,
    e_state_clear,
    e_state_ready,
    e_state_stream
  } cmd_state_e;

  typedef struct packed {
    msg_type_e  msg_type;
    msg_subop_e subop;
    msg_size_e  size;
    addr_t      addr;
    tag_t       tag;
  } mem_hdr_s;

  localparam int HDR_WIDTH_LP = $bits(mem_hdr_s);

endpackage

// File: hw/cache_pkt_if.sv
/* packet channel from the command adapter to one cache bank */
`timescale 1ns/10ps

interface cache_pkt_if
  import mem_cache_pkg::*;
();

  logic      v;
  logic      ready;
  cache_op_e opcode;
  addr_t     addr;
  data_t     data;

  modport adapter (
    output v, opcode, addr, data,
    input  ready
  );

  modport bank (
    input  v, opcode, addr, data,
    output ready
  );

endinterface

// File: hw/cache_resp_if.sv
/* response channel from one cache bank to the collector */
`timescale 1ns/10ps

interface cache_resp_if
  import mem_cache_pkg::*;
();

  logic  v;
  logic  yumi;
  data_t data;

  // yumi is a consume strobe, only legal while v is high
  modport bank (output v, data, input yumi);

  modport collector (input v, data, output yumi);

endinterface

// File: hw/cmd_to_cache.sv
/* command adapter: tag clear after reset, opcode translation,
   block stream address stepping and bank steering */
`timescale 1ns/10ps

module cmd_to_cache
  import mem_cache_pkg::*;
(
  input  logic         clk_i,
  input  logic         reset_i,
  input  mem_hdr_s     mem_cmd_header_i,
  input  data_t        mem_cmd_data_i,
  input  logic         mem_cmd_v_i,
  input  logic         mem_cmd_last_i,
  output logic         mem_cmd_ready_o,
  cache_pkt_if.adapter pkt [NUM_BANKS_LP],
  output logic         order_v_o,
  output bank_id_t     order_bank_o,
  output mem_hdr_s     order_hdr_o,
  output logic         order_last_o,
  input  logic         order_ready_i
);

  cmd_state_e state_r;
  cmd_state_e state_n;
  set_idx_t   clear_set_r;
  mem_hdr_s   hdr_r;
  word_idx_t  beat_r;
  word_idx_t  word_r;

  mem_hdr_s   hdr;
  cache_op_e  op;
  addr_t      pkt_addr;
  addr_t      clear_addr;
  bank_id_t   bank;
  word_idx_t  beat;
  word_idx_t  word;
  word_idx_t  last_beat;
  logic       is_clear;
  logic       is_stream;
  logic       active;
  logic       is_block;
  logic       need_word;
  logic       last_pkt;
  logic       issue_v;
  logic       fire;
  logic       clear_adv;
  logic [NUM_BANKS_LP-1:0] bank_ready;

  function automatic cache_op_e decode_op(mem_hdr_s h);
    logic word_op;
    word_op = (h.size == e_size_4);
    case (h.msg_type)
      e_type_rd:
        case (h.size)
          e_size_1: decode_op = e_op_lb;
          e_size_2: decode_op = e_op_lh;
          e_size_4: decode_op = e_op_lw;
          default:  decode_op = e_op_ld;
        endcase
      e_type_wr:
        case (h.size)
          e_size_1: decode_op = e_op_sb;
          e_size_2: decode_op = e_op_sh;
          e_size_4: decode_op = e_op_sw;
          default:  decode_op = e_op_sd;
        endcase
      default:
        if (h.subop == e_subop_amoadd)
          decode_op = word_op ? e_op_amoadd_w : e_op_amoadd_d;
        else
          decode_op = word_op ? e_op_amoswap_w : e_op_amoswap_d;
    endcase
  endfunction

  assign is_clear  = (state_r == e_state_clear);
  assign is_stream = (state_r == e_state_stream);
  assign active    = (state_r == e_state_ready) || is_stream;

  // the header is held internally once a block has started
  assign hdr       = is_stream ? hdr_r : mem_cmd_header_i;
  assign op        = decode_op(hdr);
  assign bank      = hdr.addr[BANK_BIT_LP];
  assign is_block  = (hdr.size == e_size_16) || (hdr.size == e_size_32);
  assign last_beat = (hdr.size == e_size_32) ? 2'd3 : 2'd1;
  assign beat      = is_stream ? beat_r : 2'd0;
  assign word      = is_stream ? word_r : hdr.addr[WORD_LSB_LP +: 2];
  assign pkt_addr  = is_block ? {hdr.addr[11:BANK_BIT_LP], word, 3'b000} : hdr.addr;

  // a block read comes in as a single command word, later packets need no input
  assign need_word = !(is_stream && hdr.msg_type == e_type_rd);
  assign last_pkt  = !is_block || (beat == last_beat)
                     || (hdr.msg_type == e_type_wr && mem_cmd_last_i);

  assign issue_v   = active && (mem_cmd_v_i || !need_word) && order_ready_i;
  assign fire      = issue_v && bank_ready[bank];
  assign mem_cmd_ready_o = active && need_word && order_ready_i && bank_ready[bank];

  assign clear_addr = addr_t'(clear_set_r) << SET_LSB_LP;
  assign clear_adv  = is_clear && (&bank_ready);

  for (genvar g = 0; g < NUM_BANKS_LP; g++)
  begin : g_bank
    assign bank_ready[g] = pkt[g].ready;
    assign pkt[g].v      = is_clear || (issue_v && bank == bank_id_t'(g));
    assign pkt[g].opcode = is_clear ? e_op_tagst : op;
    assign pkt[g].addr   = is_clear ? clear_addr : pkt_addr;
    assign pkt[g].data   = mem_cmd_data_i;
  end

  assign order_v_o    = fire;
  assign order_bank_o = bank;
  assign order_hdr_o  = hdr;
  assign order_last_o = last_pkt;

  always_comb
  begin
    state_n = state_r;
    case (state_r)
      e_state_reset:
        state_n = e_state_clear;
      e_state_clear:
        if (clear_adv && clear_set_r == set_idx_t'(SETS_LP - 1))
          state_n = e_state_ready;
      default:
        if (fire)
          state_n = last_pkt ? e_state_ready : e_state_stream;
    endcase
  end

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      state_r     <= e_state_reset;
      clear_set_r <= '0;
    end
    else
    begin
      state_r <= state_n;
      if (clear_adv)
        clear_set_r <= clear_set_r + 1'b1;
    end
  end

  // word index wraps inside the line
  always_ff @(posedge clk_i)
  begin
    if (fire)
    begin
      hdr_r  <= hdr;
      beat_r <= beat + 1'b1;
      word_r <= word + 1'b1;
    end
  end

endmodule

// File: hw/cache_bank.sv
/* one cache bank: data array with per-word valid bits,
   byte-lane load/store, swap/add atomics and a response register */
`timescale 1ns/10ps

module cache_bank
  import mem_cache_pkg::*;
(
  input  logic       clk_i,
  input  logic       reset_i,
  cache_pkt_if.bank  pkt,
  cache_resp_if.bank resp
);

  data_t                        data_r  [SETS_LP][WORDS_PER_LINE_LP];
  logic [WORDS_PER_LINE_LP-1:0] valid_r [SETS_LP];
  logic                         out_v_r;
  data_t                        out_data_r;

  set_idx_t   set;
  word_idx_t  word;
  data_t      old_word;
  data_t      lane_mask;
  data_t      old_lane;
  data_t      wr_lane;
  data_t      new_word;
  logic [5:0] shamt;
  logic       is_store;
  logic       is_amo;
  logic       accept;

  assign set      = pkt.addr[SET_LSB_LP +: 3];
  assign word     = pkt.addr[WORD_LSB_LP +: 2];
  // words not written since the line was cleared read as zero
  assign old_word = valid_r[set][word] ? data_r[set][word] : '0;

  assign pkt.ready = !out_v_r || resp.yumi;
  assign accept    = pkt.v && pkt.ready;

  always_comb
  begin
    lane_mask = '1;
    shamt     = '0;
    case (pkt.opcode)
      e_op_lb, e_op_sb:
      begin
        lane_mask = 64'hff;
        shamt     = {pkt.addr[2:0], 3'b000};
      end
      e_op_lh, e_op_sh:
      begin
        lane_mask = 64'hffff;
        shamt     = {pkt.addr[2:1], 4'b0000};
      end
      e_op_lw, e_op_sw, e_op_amoswap_w, e_op_amoadd_w:
      begin
        lane_mask = 64'hffff_ffff;
        shamt     = {pkt.addr[2], 5'b00000};
      end
      default:
      begin
        lane_mask = '1;
        shamt     = '0;
      end
    endcase
  end

  assign is_store = pkt.opcode inside {e_op_sb, e_op_sh, e_op_sw, e_op_sd};
  assign is_amo   = pkt.opcode inside {e_op_amoswap_w, e_op_amoswap_d,
                                       e_op_amoadd_w, e_op_amoadd_d};

  assign old_lane = (old_word >> shamt) & lane_mask;
  assign wr_lane  = (pkt.opcode inside {e_op_amoadd_w, e_op_amoadd_d})
                    ? (old_lane + pkt.data) & lane_mask
                    : pkt.data & lane_mask;
  assign new_word = (old_word & ~(lane_mask << shamt)) | (wr_lane << shamt);

  always_ff @(posedge clk_i)
  begin
    if (accept && pkt.opcode == e_op_tagst)
      valid_r[set] <= '0;
    else if (accept && (is_store || is_amo))
    begin
      data_r[set][word]  <= new_word;
      valid_r[set][word] <= 1'b1;
    end
  end

  // tag stores produce no response
  always_ff @(posedge clk_i)
  begin
    if (reset_i)
      out_v_r <= 1'b0;
    else if (accept && pkt.opcode != e_op_tagst)
      out_v_r <= 1'b1;
    else if (resp.yumi)
      out_v_r <= 1'b0;
  end

  // stores answer zero, loads and atomics the old lane
  always_ff @(posedge clk_i)
  begin
    if (accept && pkt.opcode != e_op_tagst)
      out_data_r <= is_store ? '0 : old_lane;
  end

  assign resp.v    = out_v_r;
  assign resp.data = out_data_r;

endmodule

// File: hw/resp_collector.sv
/* in-order response drain: order FIFO of bank, header and last flag,
   head entry picks the bank whose word is forwarded */
`timescale 1ns/10ps

module resp_collector
  import mem_cache_pkg::*;
(
  input  logic             clk_i,
  input  logic             reset_i,
  input  logic             order_v_i,
  input  bank_id_t         order_bank_i,
  input  mem_hdr_s         order_hdr_i,
  input  logic             order_last_i,
  output logic             order_ready_o,
  cache_resp_if.collector  resp [NUM_BANKS_LP],
  output mem_hdr_s         mem_resp_header_o,
  output data_t            mem_resp_data_o,
  output logic             mem_resp_v_o,
  output logic             mem_resp_last_o,
  input  logic             mem_resp_yumi_i
);

  bank_id_t                       fifo_bank_r [ORDER_FIFO_DEPTH_LP];
  mem_hdr_s                       fifo_hdr_r  [ORDER_FIFO_DEPTH_LP];
  logic [ORDER_FIFO_DEPTH_LP-1:0] fifo_last_r;
  logic [ORDER_PTR_WIDTH_LP-1:0]  wr_ptr_r;
  logic [ORDER_PTR_WIDTH_LP-1:0]  rd_ptr_r;
  logic [ORDER_PTR_WIDTH_LP:0]    count_r;

  logic [NUM_BANKS_LP-1:0] bank_v;
  data_t                   bank_data [NUM_BANKS_LP];
  bank_id_t                head_bank;
  logic                    fifo_empty;

  assign fifo_empty    = (count_r == '0);
  assign order_ready_o = (count_r != (ORDER_PTR_WIDTH_LP + 1)'(ORDER_FIFO_DEPTH_LP));
  assign head_bank     = fifo_bank_r[rd_ptr_r];

  for (genvar g = 0; g < NUM_BANKS_LP; g++)
  begin : g_bank
    assign bank_v[g]    = resp[g].v;
    assign bank_data[g] = resp[g].data;
    assign resp[g].yumi = mem_resp_yumi_i && !fifo_empty && head_bank == bank_id_t'(g);
  end

  assign mem_resp_v_o      = !fifo_empty && bank_v[head_bank];
  assign mem_resp_data_o   = bank_data[head_bank];
  assign mem_resp_header_o = fifo_hdr_r[rd_ptr_r];
  assign mem_resp_last_o   = fifo_last_r[rd_ptr_r];

  always_ff @(posedge clk_i)
  begin
    if (order_v_i)
    begin
      fifo_bank_r[wr_ptr_r] <= order_bank_i;
      fifo_hdr_r[wr_ptr_r]  <= order_hdr_i;
      fifo_last_r[wr_ptr_r] <= order_last_i;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      wr_ptr_r <= '0;
      rd_ptr_r <= '0;
      count_r  <= '0;
    end
    else
    begin
      if (order_v_i)
        wr_ptr_r <= wr_ptr_r + 1'b1;
      if (mem_resp_yumi_i)
        rd_ptr_r <= rd_ptr_r + 1'b1;
      count_r <= count_r + order_v_i - mem_resp_yumi_i;
    end
  end

endmodule

// File: hw/mem_cache_top.sv
/* memory command to cache front end: adapter, two banks, response collector */
`timescale 1ns/10ps

module mem_cache_top
  import mem_cache_pkg::*;
(
  input  logic                    clk_i,
  input  logic                    reset_i,

  input  logic [HDR_WIDTH_LP-1:0] mem_cmd_header_i,
  input  logic [63:0]             mem_cmd_data_i,
  input  logic                    mem_cmd_v_i,
  input  logic                    mem_cmd_last_i,
  output logic                    mem_cmd_ready_o,

  output logic [HDR_WIDTH_LP-1:0] mem_resp_header_o,
  output logic [63:0]             mem_resp_data_o,
  output logic                    mem_resp_v_o,
  output logic                    mem_resp_last_o,
  input  logic                    mem_resp_yumi_i
);

  cache_pkt_if  pkt  [NUM_BANKS_LP] ();
  cache_resp_if resp [NUM_BANKS_LP] ();

  logic     order_v;
  bank_id_t order_bank;
  mem_hdr_s order_hdr;
  logic     order_last;
  logic     order_ready;

  cmd_to_cache u_cmd_to_cache (
    .clk_i            (clk_i),
    .reset_i          (reset_i),
    .mem_cmd_header_i (mem_cmd_header_i),
    .mem_cmd_data_i   (mem_cmd_data_i),
    .mem_cmd_v_i      (mem_cmd_v_i),
    .mem_cmd_last_i   (mem_cmd_last_i),
    .mem_cmd_ready_o  (mem_cmd_ready_o),
    .pkt              (pkt),
    .order_v_o        (order_v),
    .order_bank_o     (order_bank),
    .order_hdr_o      (order_hdr),
    .order_last_o     (order_last),
    .order_ready_i    (order_ready)
  );

  for (genvar g = 0; g < NUM_BANKS_LP; g++)
  begin : g_bank
    cache_bank u_cache_bank (
      .clk_i   (clk_i),
      .reset_i (reset_i),
      .pkt     (pkt[g]),
      .resp    (resp[g])
    );
  end

  resp_collector u_resp_collector (
    .clk_i             (clk_i),
    .reset_i           (reset_i),
    .order_v_i         (order_v),
    .order_bank_i      (order_bank),
    .order_hdr_i       (order_hdr),
    .order_last_i      (order_last),
    .order_ready_o     (order_ready),
    .resp              (resp),
    .mem_resp_header_o (mem_resp_header_o),
    .mem_resp_data_o   (mem_resp_data_o),
    .mem_resp_v_o      (mem_resp_v_o),
    .mem_resp_last_o   (mem_resp_last_o),
    .mem_resp_yumi_i   (mem_resp_yumi_i)
  );

endmodule

// File: tests/mem_cache_assert.sv
/* handshake, command type and reset clear assertions, bound to the adapter */
`timescale 1ns/10ps

module mem_cache_assert
  import mem_cache_pkg::*;
(
  input logic       clk_i,
  input logic       reset_i,
  input logic       mem_cmd_v_i,
  input mem_hdr_s   mem_cmd_header_i,
  input logic       mem_cmd_ready_o,
  input logic       issue_v,
  input logic       fire,
  input cache_op_e  op,
  input addr_t      pkt_addr,
  input bank_id_t   bank
);

  logic [3:0] cycles_r;

  // cycles since reset, held once the clear window is over
  always_ff @(posedge clk_i)
  begin
    if (reset_i)
      cycles_r <= '0;
    else if (cycles_r != 4'(SETS_LP))
      cycles_r <= cycles_r + 1'b1;
  end

  // only swap and add atomics are supported
  assert property (@(posedge clk_i) disable iff (reset_i)
    (mem_cmd_v_i && mem_cmd_header_i.msg_type == e_type_amo)
      |-> (mem_cmd_header_i.subop inside {e_subop_amoswap, e_subop_amoadd}))
    else $error("LR/SC or unknown atomic command");

  // a stalled packet holds its fields
  assert property (@(posedge clk_i) disable iff (reset_i)
    (issue_v && !fire) |=> ($stable(op) && $stable(pkt_addr) && $stable(bank)))
    else $error("packet changed while stalled");

  // the 16 tag stores go out at most one per bank per cycle
  assert property (@(posedge clk_i) disable iff (reset_i)
    (cycles_r < 4'(SETS_LP)) |-> !mem_cmd_ready_o)
    else $error("command ready before the tag clear finished");

endmodule

bind cmd_to_cache mem_cache_assert u_mem_cache_assert (
  .clk_i            (clk_i),
  .reset_i          (reset_i),
  .mem_cmd_v_i      (mem_cmd_v_i),
  .mem_cmd_header_i (mem_cmd_header_i),
  .mem_cmd_ready_o  (mem_cmd_ready_o),
  .issue_v          (issue_v),
  .fire             (fire),
  .op               (op),
  .pkt_addr         (pkt_addr),
  .bank             (bank)
);

// File: tests/tb_mem_cache.sv
/* testbench for the memory command to cache front end,
   golden file stimulus, random response stalls and in-order checks */
`timescale 1ns/10ps

module tb_mem_cache
  import mem_cache_pkg::*;
();

  localparam int CLK_PERIOD      = 100;
  localparam int RESET_CYCLES    = 8;
  localparam int MAX_TESTS       = 64;
  localparam int GOLDEN_WORDS    = 512;
  localparam int CYCLES_PER_TEST = 200;

  logic     clk_i;
  logic     reset_i;
  mem_hdr_s cmd_hdr;
  data_t    cmd_data;
  logic     cmd_v;
  logic     cmd_last;
  logic     cmd_ready;
  mem_hdr_s resp_hdr;
  data_t    resp_data;
  logic     resp_v;
  logic     resp_last;
  logic     resp_yumi;

  data_t    golden_mem [GOLDEN_WORDS];
  mem_hdr_s test_hdr [MAX_TESTS];
  int       cmd_idx [MAX_TESTS];
  int       cmd_cnt [MAX_TESTS];
  int       exp_idx [MAX_TESTS];
  int       exp_cnt [MAX_TESTS];
  int       num_tests;
  int       check_count;
  int       error_count;
  logic     load_done;
  logic     cmd_fire_seen;

  mem_cache_top DUT (
    .clk_i             (clk_i),
    .reset_i           (reset_i),
    .mem_cmd_header_i  (cmd_hdr),
    .mem_cmd_data_i    (cmd_data),
    .mem_cmd_v_i       (cmd_v),
    .mem_cmd_last_i    (cmd_last),
    .mem_cmd_ready_o   (cmd_ready),
    .mem_resp_header_o (resp_hdr),
    .mem_resp_data_o   (resp_data),
    .mem_resp_v_o      (resp_v),
    .mem_resp_last_o   (resp_last),
    .mem_resp_yumi_i   (resp_yumi)
  );

  always #(CLK_PERIOD / 2) clk_i = ~clk_i;

  // command handshake seen at the edge, read back on the next falling edge
  always @(posedge clk_i)
    cmd_fire_seen <= cmd_v && cmd_ready;

  task automatic check_data(input data_t got, input data_t exp, input string what);
    check_count++;
    if (got !== exp)
    begin
      error_count++;
      $display("FAIL %0t: %s data %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_hdr(input mem_hdr_s got, input mem_hdr_s exp, input string what);
    check_count++;
    if (got !== exp)
    begin
      error_count++;
      $display("FAIL %0t: %s header %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_last(input logic got, input logic exp, input string what);
    check_count++;
    if (got !== exp)
    begin
      error_count++;
      $display("FAIL %0t: %s last %b, expected %b", $time, what, got, exp);
    end
  endtask

  // record: type subop size addr tag ncmd nresp, command words, expected words
  task automatic load_golden();
    int p;
    p = 0;
    $readmemh("tests/mem_cache_golden.txt", golden_mem);
    while (p < GOLDEN_WORDS - 8 && golden_mem[p] !== 64'hff && golden_mem[p] !== 'x
           && num_tests < MAX_TESTS)
    begin
      test_hdr[num_tests].msg_type = msg_type_e'(golden_mem[p][1:0]);
      test_hdr[num_tests].subop    = msg_subop_e'(golden_mem[p+1][2:0]);
      test_hdr[num_tests].size     = msg_size_e'(golden_mem[p+2][2:0]);
      test_hdr[num_tests].addr     = addr_t'(golden_mem[p+3]);
      test_hdr[num_tests].tag      = tag_t'(golden_mem[p+4]);
      cmd_cnt[num_tests] = int'(golden_mem[p+5]);
      exp_cnt[num_tests] = int'(golden_mem[p+6]);
      cmd_idx[num_tests] = p + 7;
      exp_idx[num_tests] = p + 7 + cmd_cnt[num_tests];
      p = exp_idx[num_tests] + exp_cnt[num_tests];
      num_tests++;
    end
  endtask

  task automatic drive_commands();
    @(negedge clk_i);
    for (int t = 0; t < num_tests; t++)
    begin
      for (int k = 0; k < cmd_cnt[t]; k++)
      begin
        cmd_hdr  = test_hdr[t];
        cmd_data = golden_mem[cmd_idx[t] + k];
        cmd_last = (k == cmd_cnt[t] - 1);
        cmd_v    = 1'b1;
        @(negedge clk_i);
        while (!cmd_fire_seen)
          @(negedge clk_i);
      end
    end
    cmd_v    = 1'b0;
    cmd_last = 1'b0;
  endtask

  task automatic collect_responses();
    int   errs_before;
    logic got;
    string what;
    for (int t = 0; t < num_tests; t++)
    begin
      errs_before = error_count;
      for (int k = 0; k < exp_cnt[t]; k++)
      begin
        got = 1'b0;
        while (!got)
        begin
          @(negedge clk_i);
          // yumi only while valid, dropped at random to stall the banks
          if (resp_v && $urandom_range(3) != 0)
          begin
            what = $sformatf("test %0d word %0d", t, k);
            check_data(resp_data, golden_mem[exp_idx[t] + k], what);
            check_hdr(resp_hdr, test_hdr[t], what);
            check_last(resp_last, k == exp_cnt[t] - 1, what);
            resp_yumi = 1'b1;
            got       = 1'b1;
          end
          else
            resp_yumi = 1'b0;
        end
      end
      $display("test %0d tag %h: %s", t, test_hdr[t].tag,
               (error_count == errs_before) ? "ok" : "mismatch");
    end
    @(negedge clk_i);
    resp_yumi = 1'b0;
  endtask

  initial
  begin
    clk_i       = 1'b0;
    reset_i     = 1'b1;
    cmd_hdr     = '0;
    cmd_data    = '0;
    cmd_v       = 1'b0;
    cmd_last    = 1'b0;
    resp_yumi   = 1'b0;
    num_tests   = 0;
    check_count = 0;
    error_count = 0;
    load_done   = 1'b0;
    void'($urandom(35));
    load_golden();
    load_done = 1'b1;
    if (num_tests == 0)
    begin
      error_count++;
      $display("no tests could be read from the golden file");
    end
    repeat (RESET_CYCLES) @(posedge clk_i);
    @(negedge clk_i);
    reset_i = 1'b0;
    if (cmd_ready !== 1'b0 || resp_v !== 1'b0)
    begin
      error_count++;
      $display("command ready or response valid is high right after reset");
    end
    fork
      drive_commands();
      collect_responses();
    join
    $display("%0d tests, %0d checks, %0d errors", num_tests, check_count, error_count);
    if (error_count == 0)
      $display("Test OK");
    else
      $display("Test FAILED");
    $finish;
  end

  initial
  begin
    wait (load_done);
    repeat (num_tests * CYCLES_PER_TEST + 4 * RESET_CYCLES) @(posedge clk_i);
    $display("timeout: responses did not complete in %0d cycles",
             num_tests * CYCLES_PER_TEST);
    $display("Test FAILED");
    $finish;
  end

endmodule

// File: tests/mem_cache_golden.txt
// type subop size addr tag ncmd nresp, then ncmd command words, then nresp expected words
// type 0 rd 1 wr 2 amo; subop 0 store 1 swap 2 add; size 0..5 = 1,2,4,8,16,32 bytes; ff ends
0 0 3 000 01 1 1 0 0
1 0 0 003 02 1 1 ab 0
1 0 1 006 03 1 1 1234 0
0 0 3 000 04 1 1 0 12340000ab000000
0 0 1 006 05 1 1 0 1234
0 0 0 003 06 1 1 0 ab
1 0 2 028 07 1 1 deadbeef 0
1 0 3 048 08 1 1 0102030405060708 0
0 0 2 02c 09 1 1 0 0
0 0 3 028 0a 1 1 0 deadbeef
2 1 2 028 0b 1 1 11111111 deadbeef
2 2 3 048 0c 1 1 10 0102030405060708
2 2 2 02c 0d 1 1 5 0
2 1 3 000 0e 1 1 ffff 12340000ab000000
0 0 3 028 0f 1 1 0 0000000511111111
0 0 3 048 10 1 1 0 0102030405060718
0 0 3 000 11 1 1 0 ffff
1 0 5 080 12 4 4 a0 a1 a2 a3 0 0 0 0
0 0 5 080 13 1 4 0 a0 a1 a2 a3
1 0 4 0f0 14 2 2 b0 b1 0 0
0 0 4 0f0 15 1 2 0 b0 b1
0 0 5 0a0 16 1 4 0 0 0 0 0
0 0 3 000 17 1 1 0 ffff
0 0 3 028 18 1 1 0 0000000511111111
0 0 2 048 19 1 1 0 05060718
0 0 0 02c 1a 1 1 0 5
ff

// File: build.f
hw/mem_cache_pkg.sv
hw/cache_pkt_if.sv
hw/cache_resp_if.sv
hw/cmd_to_cache.sv
hw/cache_bank.sv
hw/resp_collector.sv
hw/mem_cache_top.sv
tests/mem_cache_assert.sv
tests/tb_mem_cache.sv

// File: Makefile
TOP = tb_mem_cache

.PHONY: all lint clean

all: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "^Test OK$$" sim.log

obj_dir/V$(TOP): build.f hw/*.sv tests/*.sv
	verilator --binary --timing --assert -f build.f --top-module $(TOP) -o V$(TOP)

lint:
	verilator --lint-only --timing -Wall -f build.f --top-module $(TOP)

clean:
	rm -rf obj_dir sim.log
